// File: Bender.yml
package:
  name: ex_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ex_pkg.sv
      - operand_select.sv
      - alu_decode.sv
      - alu.sv
      - branch_resolve.sv
      - ex_mem_reg.sv
      - ex_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - ex_unit_props.sv
      - ex_unit_tb.sv

// File: alu.sv
`timescale 1ns/100ps
`include "ex_config.svh"
`default_nettype none

module alu
	import ex_pkg::*;
(
	input  logic [`EX_XLEN-1:0] oper_a,
	input  logic [`EX_XLEN-1:0] oper_b,
	input  alu_op_e             alu_op,
	output logic [`EX_XLEN-1:0] result
);

	localparam int SHAMT_W = $clog2(`EX_XLEN);

	logic [SHAMT_W-1:0]  shamt;
	logic [`EX_XLEN-1:0] sum;
	logic [`EX_XLEN-1:0] diff;
	logic                less;

	assign shamt = oper_b[SHAMT_W-1:0]; // Low bits only
	assign sum   = oper_a + oper_b;
	assign diff  = oper_a - oper_b;
	assign less  = $signed(oper_a) < $signed(oper_b);

	always_comb begin
		case (alu_op)
			ADD:     result = sum;
			SUB:     result = diff;
			AND:     result = oper_a & oper_b;
			OR:      result = oper_a | oper_b;
			XOR:     result = oper_a ^ oper_b;
			SLL:     result = oper_a << shamt;
			SRL:     result = oper_a >> shamt;
			SRA:     result = $unsigned($signed(oper_a) >>> shamt);
			SLT:     result = {{(`EX_XLEN-1){1'b0}}, less};
			PASS_B:  result = oper_b;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: alu_decode.sv
`timescale 1ns/100ps
`default_nettype none

module alu_decode
	import ex_pkg::*;
(
	input  opcode_e opcode,
	output alu_op_e alu_op
);

	always_comb begin
		case (opcode)
			add:    alu_op = ADD;
			sub:    alu_op = SUB;
			and_op: alu_op = AND;
			or_op:  alu_op = OR;
			xor_op: alu_op = XOR;
			sll:    alu_op = SLL;
			srl:    alu_op = SRL;
			sra:    alu_op = SRA;
			slt:    alu_op = SLT;

			// Address and link arithmetic
			addi, lw, sw, jal: alu_op = ADD;

			// Branches only need a result for the datapath, compare is done elsewhere
			beq, bne, blt, ble, bgt, bge: alu_op = ADD;

			jr:      alu_op = PASS_B;
			default: alu_op = ADD;
		endcase
	end

endmodule

`default_nettype wire

// File: branch_resolve.sv
`timescale 1ns/100ps
`include "ex_config.svh"
`default_nettype none

module branch_resolve
	import ex_pkg::*;
(
	input  ex_ctrl_t            ctrl,
	input  operands_t           operands,
	input  logic [`EX_XLEN-1:0] pfc,
	output logic                mispredict,
	output logic [`EX_XLEN-1:0] redirect_pc
);

	logic is_eq;
	logic is_lt;
	logic is_gt;
	logic taken;
	logic is_branch;

	// Signed compare of A against B
	assign is_eq = operands.oper_a == operands.oper_b;
	assign is_lt = $signed(operands.oper_a) < $signed(operands.oper_b);
	assign is_gt = $signed(operands.oper_a) > $signed(operands.oper_b);

	always_comb begin
		case (ctrl.br_kind)
			BR_EQ:   taken = is_eq;
			BR_NE:   taken = !is_eq;
			BR_LT:   taken = is_lt;
			BR_LE:   taken = is_lt || is_eq;
			BR_GT:   taken = is_gt;
			BR_GE:   taken = is_gt || is_eq;
			default: taken = 1'b0;
		endcase
	end

	assign is_branch = ctrl.valid && (ctrl.br_kind != BR_NONE);

	// Flag when fetch guessed the wrong direction
	assign mispredict = is_branch && (taken != ctrl.predicted);

	// jr jumps to the register value, otherwise hand back what fetch predicted
	always_comb begin
		if (ctrl.opcode == jr) begin
			redirect_pc = operands.oper_a;
		end else begin
			redirect_pc = pfc;
		end
	end

endmodule

`default_nettype wire

// File: ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH
`default_nettype none

`define EX_XLEN        32   // Datapath width
`define EX_REG_W       5    // Register index width
`define EX_CLK_PERIOD  100  // Testbench clock period in ns

`default_nettype wire
`endif

// File: ex_mem_reg.sv
`timescale 1ns/100ps
`include "ex_config.svh"
`default_nettype none

module ex_mem_reg
	import ex_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  ex_ctrl_t            ctrl,
	input  logic [`EX_XLEN-1:0] result,
	input  logic [`EX_XLEN-1:0] store_data,
	output ex_mem_t             ex_mem
);

	ex_mem_t nxt;

	// Filter controls before they leave the stage
	always_comb begin
		nxt.valid      = ctrl.valid;
		nxt.reg_write  = ctrl.valid && ctrl.reg_write && (ctrl.rd != '0); // No writes to r0
		nxt.mem_read   = ctrl.valid && ctrl.mem_read;
		nxt.mem_write  = ctrl.valid && ctrl.mem_write;
		nxt.rd         = ctrl.rd;
		nxt.alu_out    = result;
		nxt.store_data = store_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= nxt;
		end
	end

endmodule

`default_nettype wire

// File: ex_pkg.sv
`include "ex_config.svh"
`default_nettype none

package ex_pkg;

	// Opcodes as seen by the execute stage
	typedef enum logic [6:0] {
		add    = 7'h00,
		sub    = 7'h01,
		and_op = 7'h02,
		or_op  = 7'h03,
		xor_op = 7'h04,
		sll    = 7'h05,
		srl    = 7'h06,
		sra    = 7'h07,
		slt    = 7'h08,
		addi   = 7'h09,
		lw     = 7'h0a,
		sw     = 7'h0b,
		beq    = 7'h0c,
		bne    = 7'h0d,
		blt    = 7'h0e,
		ble    = 7'h0f,
		bgt    = 7'h10,
		bge    = 7'h11,
		jr     = 7'h12,
		jal    = 7'h13
	} opcode_e;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_LE, BR_GT, BR_GE
	} br_kind_e;

	// Forwarding mux selects, driven by hazard logic upstream
	typedef enum logic [1:0] {
		SEL_A_PC, SEL_A_EX, SEL_A_MEM, SEL_A_RS1
	} sel_a_e;

	typedef enum logic [2:0] {
		SEL_B_IMM, SEL_B_ONE, SEL_B_EX, SEL_B_MEM, SEL_B_RS2
	} sel_b_e;

	typedef enum logic [1:0] {
		SEL_ST_RS2, SEL_ST_EX, SEL_ST_MEM
	} sel_st_e;

	typedef struct packed {
		logic                 valid;
		opcode_e              opcode;
		br_kind_e             br_kind;
		logic                 predicted; // Fetch guessed taken
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic [`EX_REG_W-1:0] rd;
		sel_a_e               sel_a;
		sel_b_e               sel_b;
		sel_st_e              sel_st;
	} ex_ctrl_t;

	typedef struct packed {
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_XLEN-1:0] pfc;     // Predicted next PC from fetch
		logic [`EX_XLEN-1:0] rs1;
		logic [`EX_XLEN-1:0] rs2;
		logic [`EX_XLEN-1:0] imm;
		logic [`EX_XLEN-1:0] ex_fwd;  // EX/MEM bypass
		logic [`EX_XLEN-1:0] mem_fwd; // MEM/WB bypass
	} ex_data_t;

	typedef struct packed {
		logic                 valid;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic [`EX_REG_W-1:0] rd;
		logic [`EX_XLEN-1:0]  alu_out;
		logic [`EX_XLEN-1:0]  store_data;
	} ex_mem_t;

	typedef struct packed {
		logic [`EX_XLEN-1:0] oper_a;
		logic [`EX_XLEN-1:0] oper_b;
		logic [`EX_XLEN-1:0] store_data;
	} operands_t;

endpackage

`default_nettype wire

// File: ex_unit.f
+incdir+.
ex_pkg.sv
operand_select.sv
alu_decode.sv
alu.sv
branch_resolve.sv
ex_mem_reg.sv
ex_unit.sv
ex_unit_props.sv
ex_unit_tb.sv

// File: ex_unit.sv
`timescale 1ns/100ps
`include "ex_config.svh"
`default_nettype none

module ex_unit
	import ex_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  ex_ctrl_t            ctrl,
	input  ex_data_t            data,
	output ex_mem_t             ex_mem,
	output logic                mispredict,
	output logic [`EX_XLEN-1:0] redirect_pc
);

	operands_t           operands;
	alu_op_e             alu_op;
	logic [`EX_XLEN-1:0] result;

	operand_select u_operand_select (
		.ctrl     (ctrl),
		.data     (data),
		.operands (operands)
	);

	alu_decode u_alu_decode (
		.opcode (ctrl.opcode),
		.alu_op (alu_op)
	);

	alu u_alu (
		.oper_a (operands.oper_a),
		.oper_b (operands.oper_b),
		.alu_op (alu_op),
		.result (result)
	);

	// Feeds fetch directly, no register
	branch_resolve u_branch_resolve (
		.ctrl        (ctrl),
		.operands    (operands),
		.pfc         (data.pfc),
		.mispredict  (mispredict),
		.redirect_pc (redirect_pc)
	);

	ex_mem_reg u_ex_mem_reg (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.result     (result),
		.store_data (operands.store_data),
		.ex_mem     (ex_mem)
	);

endmodule

`default_nettype wire

// File: ex_unit_props.sv
`timescale 1ns/100ps
`default_nettype none

module ex_unit_props
	import ex_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input ex_ctrl_t ctrl,
	input ex_mem_t  ex_mem,
	input logic     mispredict
);

	int unsigned fail_count = 0;

	// No redirect request without an instruction
	mis_needs_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		!ctrl.valid |-> !mispredict
	) else begin
		$error("mispredict is high while ctrl.valid is low");
		fail_count++;
	end

	valid_follows_ctrl: assert property (
		@(posedge clk) disable iff (!rst_n)
		1'b1 |=> (ex_mem.valid == $past(ctrl.valid))
	) else begin
		$error("ex_mem.valid does not match ctrl.valid of the previous cycle");
		fail_count++;
	end

	no_write_to_r0: assert property (
		@(posedge clk) disable iff (!rst_n)
		ex_mem.reg_write |-> (ex_mem.rd != '0)
	) else begin
		$error("ex_mem.reg_write is set with rd equal to zero");
		fail_count++;
	end

	// Load and store are exclusive
	one_mem_op: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(ex_mem.mem_read && ex_mem.mem_write)
	) else begin
		$error("ex_mem.mem_read and ex_mem.mem_write are both high");
		fail_count++;
	end

endmodule

bind ex_unit ex_unit_props u_ex_unit_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.ctrl       (ctrl),
	.ex_mem     (ex_mem),
	.mispredict (mispredict)
);

`default_nettype wire

// File: ex_unit_tb.sv
`timescale 1ns/100ps
`include "ex_config.svh"
`default_nettype none

module ex_unit_tb
	import ex_pkg::*;
();

	localparam int N_RANDOM = 200;
	localparam int CW = $bits(ex_mem_t);

	typedef struct packed {
		ex_ctrl_t            ctrl;
		ex_data_t            data;
		logic                mis;
		logic [`EX_XLEN-1:0] redirect;
		ex_mem_t             ex_mem;
	} vec_t;

	logic                clk;
	logic                rst_n;
	ex_ctrl_t            ctrl;
	ex_data_t            data;
	ex_mem_t             ex_mem;
	logic                mispredict;
	logic [`EX_XLEN-1:0] redirect_pc;

	vec_t  vecs[$];
	string names[$];
	bit    table_ready;

	ex_unit uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.ctrl        (ctrl),
		.data        (data),
		.ex_mem      (ex_mem),
		.mispredict  (mispredict),
		.redirect_pc (redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #(`EX_CLK_PERIOD / 2) clk = ~clk;
	end

	// Reference model of the stage
	function automatic vec_t model_expect(input ex_ctrl_t c, input ex_data_t d);
		vec_t                       v;
		logic [`EX_XLEN-1:0]        a;
		logic [`EX_XLEN-1:0]        b;
		logic [`EX_XLEN-1:0]        st;
		logic [`EX_XLEN-1:0]        res;
		logic signed [`EX_XLEN-1:0] sa;
		logic signed [`EX_XLEN-1:0] sb;
		logic                       take;
		a = (c.sel_a == SEL_A_PC) ? d.pc : (c.sel_a == SEL_A_EX) ? d.ex_fwd :
			(c.sel_a == SEL_A_MEM) ? d.mem_fwd : d.rs1;
		b = (c.sel_b == SEL_B_IMM) ? d.imm : (c.sel_b == SEL_B_ONE) ? 32'd1 :
			(c.sel_b == SEL_B_EX) ? d.ex_fwd : (c.sel_b == SEL_B_MEM) ? d.mem_fwd : d.rs2;
		st = (c.sel_st == SEL_ST_EX) ? d.ex_fwd : (c.sel_st == SEL_ST_MEM) ? d.mem_fwd : d.rs2;
		sa = a;
		sb = b;
		case (c.opcode)
			sub:     res = a - b;
			and_op:  res = a & b;
			or_op:   res = a | b;
			xor_op:  res = a ^ b;
			sll:     res = a << b[4:0];
			srl:     res = a >> b[4:0];
			sra:     res = sa >>> b[4:0];
			slt:     res = (sa < sb) ? 32'd1 : 32'd0;
			jr:      res = b;
			default: res = a + b; // Plain add, addresses, links, branches
		endcase
		case (c.br_kind)
			BR_EQ:   take = (sa == sb);
			BR_NE:   take = (sa != sb);
			BR_LT:   take = (sa < sb);
			BR_LE:   take = (sa <= sb);
			BR_GT:   take = (sa > sb);
			BR_GE:   take = (sa >= sb);
			default: take = 1'b0;
		endcase
		v.ctrl = c;
		v.data = d;
		v.mis = c.valid && (c.br_kind != BR_NONE) && (take != c.predicted);
		v.redirect = (c.opcode == jr) ? a : d.pfc;
		v.ex_mem.valid = c.valid;
		v.ex_mem.reg_write = c.valid && c.reg_write && (c.rd != '0);
		v.ex_mem.mem_read = c.valid && c.mem_read;
		v.ex_mem.mem_write = c.valid && c.mem_write;
		v.ex_mem.rd = c.rd;
		v.ex_mem.alu_out = res;
		v.ex_mem.store_data = st;
		return v;
	endfunction

	// Controls as the decode stage would set them
	function automatic ex_ctrl_t ctrl_for(input opcode_e op, input sel_a_e sa, input sel_b_e sb,
			input sel_st_e sst, input logic [`EX_REG_W-1:0] rd, input logic pred,
			input logic valid);
		ex_ctrl_t c;
		c = '0;
		c.valid = valid;
		c.opcode = op;
		c.predicted = pred;
		c.rd = rd;
		c.sel_a = sa;
		c.sel_b = sb;
		c.sel_st = sst;
		case (op)
			beq: c.br_kind = BR_EQ;
			bne: c.br_kind = BR_NE;
			blt: c.br_kind = BR_LT;
			ble: c.br_kind = BR_LE;
			bgt: c.br_kind = BR_GT;
			bge: c.br_kind = BR_GE;
			lw: begin
				c.mem_read = 1'b1;
				c.reg_write = 1'b1;
			end
			sw: c.mem_write = 1'b1;
			jr: c.reg_write = 1'b0;
			default: c.reg_write = 1'b1;
		endcase
		return c;
	endfunction

	task automatic push_vec(input string name, input ex_ctrl_t c, input ex_data_t d);
		vecs.push_back(model_expect(c, d));
		names.push_back(name);
	endtask

	// Operand values go to the selected sources, the rest keep distinct fill values
	task automatic table_row(input string name, input opcode_e op, input sel_a_e sa,
			input sel_b_e sb, input sel_st_e sst, input logic [`EX_XLEN-1:0] a_val,
			input logic [`EX_XLEN-1:0] b_val, input logic [`EX_REG_W-1:0] rd,
			input logic pred, input logic valid);
		ex_data_t d;
		d.pc = 32'h0000_1000;
		d.pfc = 32'h0000_1004;
		d.rs1 = 32'h1111_0001;
		d.rs2 = 32'h2222_0002;
		d.imm = 32'h0000_0010;
		d.ex_fwd = 32'h3333_0003;
		d.mem_fwd = 32'h4444_0004;
		case (sa)
			SEL_A_PC:  d.pc = a_val;
			SEL_A_EX:  d.ex_fwd = a_val;
			SEL_A_MEM: d.mem_fwd = a_val;
			default:   d.rs1 = a_val;
		endcase
		case (sb)
			SEL_B_IMM: d.imm = b_val;
			SEL_B_EX:  d.ex_fwd = b_val;
			SEL_B_MEM: d.mem_fwd = b_val;
			SEL_B_RS2: d.rs2 = b_val;
			default: ;
		endcase
		push_vec(name, ctrl_for(op, sa, sb, sst, rd, pred, valid), d);
	endtask

	task automatic build_directed();
		table_row("add_rr", add, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 7, 5, 5'd3, 1'b0, 1'b1);
		table_row("sub_neg", sub, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 3, 7, 5'd4, 1'b0, 1'b1);
		table_row("and_rr", and_op, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 'hf0f0, 'hff00, 5'd5,
			1'b0, 1'b1);
		table_row("or_rr", or_op, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 'hf0f0, 'h0f0f, 5'd6,
			1'b0, 1'b1);
		table_row("xor_rr", xor_op, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 'haaaa, 'hffff, 5'd7,
			1'b0, 1'b1);
		table_row("sll_rr", sll, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 1, 'h24, 5'd8, 1'b0, 1'b1);
		table_row("srl_rr", srl, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 'h8000_0000, 31, 5'd9,
			1'b0, 1'b1);
		table_row("sra_neg", sra, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 'hf000_0000, 'h44, 5'd10,
			1'b0, 1'b1);
		table_row("slt_neg", slt, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, -5, 3, 5'd11, 1'b0, 1'b1);
		table_row("slt_pos", slt, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 3, -5, 5'd12, 1'b0, 1'b1);
		table_row("addi_neg", addi, SEL_A_RS1, SEL_B_IMM, SEL_ST_RS2, 'h40, -16, 5'd13,
			1'b0, 1'b1);
		table_row("lw_addr", lw, SEL_A_RS1, SEL_B_IMM, SEL_ST_RS2, 'h200, 8, 5'd14, 1'b0, 1'b1);
		table_row("sw_rs2", sw, SEL_A_RS1, SEL_B_IMM, SEL_ST_RS2, 'h300, 4, 5'd0, 1'b0, 1'b1);
		table_row("sw_ex", sw, SEL_A_RS1, SEL_B_IMM, SEL_ST_EX, 'h300, 4, 5'd0, 1'b0, 1'b1);
		table_row("sw_mem", sw, SEL_A_RS1, SEL_B_IMM, SEL_ST_MEM, 'h300, 4, 5'd0, 1'b0, 1'b1);
		table_row("fwd_a_ex", add, SEL_A_EX, SEL_B_RS2, SEL_ST_RS2, 'h50, 1, 5'd15, 1'b0, 1'b1);
		table_row("fwd_a_mem", add, SEL_A_MEM, SEL_B_RS2, SEL_ST_RS2, 'h60, 1, 5'd16, 1'b0, 1'b1);
		table_row("fwd_b_ex", sub, SEL_A_RS1, SEL_B_EX, SEL_ST_RS2, 'h70, 'h10, 5'd17, 1'b0, 1'b1);
		table_row("fwd_b_mem", sub, SEL_A_RS1, SEL_B_MEM, SEL_ST_RS2, 'h80, 'h10, 5'd18,
			1'b0, 1'b1);
		table_row("jal_link", jal, SEL_A_PC, SEL_B_ONE, SEL_ST_RS2, 'h2000, 0, 5'd31, 1'b0, 1'b1);
		table_row("beq_eq", beq, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, -3, -3, 5'd0, 1'b1, 1'b1);
		table_row("beq_ne", beq, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, -3, 3, 5'd0, 1'b1, 1'b1);
		table_row("bne_eq", bne, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 9, 9, 5'd0, 1'b1, 1'b1);
		table_row("blt_neg", blt, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, -8, 2, 5'd0, 1'b0, 1'b1);
		table_row("blt_gt", blt, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 6, -6, 5'd0, 1'b0, 1'b1);
		table_row("ble_eq", ble, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, -4, -4, 5'd0, 1'b1, 1'b1);
		table_row("bgt_lt", bgt, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, -1, 1, 5'd0, 1'b1, 1'b1);
		table_row("bgt_max", bgt, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 'h7fff_ffff, 'h8000_0000,
			5'd0, 1'b1, 1'b1);
		table_row("bge_gt", bge, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 5, -5, 5'd0, 1'b0, 1'b1);
		table_row("bge_fwd", bge, SEL_A_EX, SEL_B_MEM, SEL_ST_RS2, -2, -2, 5'd0, 1'b1, 1'b1);
		table_row("jr_rs1", jr, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 'h2468, 0, 5'd0, 1'b0, 1'b1);
		table_row("jr_fwd", jr, SEL_A_MEM, SEL_B_RS2, SEL_ST_RS2, 'h1358, 0, 5'd0, 1'b0, 1'b1);
		table_row("rd_zero", add, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 1, 2, 5'd0, 1'b0, 1'b1);
		table_row("inv_lw", lw, SEL_A_RS1, SEL_B_IMM, SEL_ST_RS2, 'h100, 4, 5'd5, 1'b0, 1'b0);
		table_row("inv_sw", sw, SEL_A_RS1, SEL_B_IMM, SEL_ST_EX, 'h100, 4, 5'd0, 1'b0, 1'b0);
		table_row("inv_beq", beq, SEL_A_RS1, SEL_B_RS2, SEL_ST_RS2, 1, 2, 5'd0, 1'b1, 1'b0);
	endtask

	task automatic random_rows(input int count);
		ex_ctrl_t    c;
		ex_data_t    d;
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			r = $urandom;
			c = ctrl_for(opcode_e'($urandom_range(0, 19)), sel_a_e'($urandom_range(0, 3)),
				sel_b_e'($urandom_range(0, 4)), sel_st_e'($urandom_range(0, 2)),
				r[`EX_REG_W-1:0], r[8], r[11:9] != 3'd0);
			d = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
			if (r[13:12] == 2'd0) begin // Equal operands for branch compares
				d.rs2 = d.rs1;
				d.imm = d.rs1;
				d.mem_fwd = d.ex_fwd;
			end
			push_vec($sformatf("random_%0d", i), c, d);
		end
	endtask

	task automatic report_mismatch(input string test, input string what,
			input logic [CW-1:0] expected, input logic [CW-1:0] actual);
		$display("Fail %s %s: expected %0h, actual %0h", test, what, expected, actual);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	initial begin
		wait (table_ready);
		#((8 + vecs.size() + 10) * `EX_CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles",
			8 + vecs.size() + 10);
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	initial begin
		vec_t cur;
		void'($urandom(32'h3322d596));
		rst_n = 1'b0;
		ctrl = '0;
		data = '0;
		build_directed();
		random_rows(N_RANDOM);
		table_ready = 1'b1;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		assert (ex_mem === '0) else report_mismatch("reset", "ex_mem", '0, ex_mem);
		for (int i = 0; i < vecs.size(); i++) begin
			cur = vecs[i];
			ctrl = cur.ctrl;
			data = cur.data;
			#(`EX_CLK_PERIOD / 2 - 1); // Just before the rising edge
			assert (mispredict === cur.mis)
				else report_mismatch(names[i], "mispredict", cur.mis, mispredict);
			assert (redirect_pc === cur.redirect)
				else report_mismatch(names[i], "redirect_pc", cur.redirect, redirect_pc);
			@(negedge clk);
			assert (ex_mem === cur.ex_mem)
				else report_mismatch(names[i], "ex_mem", cur.ex_mem, ex_mem);
		end
		if (uut.u_ex_unit_props.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("The bound property checker saw %0d assertion failures",
				uut.u_ex_unit_props.fail_count);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: operand_select.sv
`timescale 1ns/100ps
`include "ex_config.svh"
`default_nettype none

module operand_select
	import ex_pkg::*;
(
	input  ex_ctrl_t  ctrl,
	input  ex_data_t  data,
	output operands_t operands
);

	logic [`EX_XLEN-1:0] oper_a;
	logic [`EX_XLEN-1:0] oper_b;
	logic [`EX_XLEN-1:0] store_data;

	// Operand A
	always_comb begin
		case (ctrl.sel_a)
			SEL_A_PC:  oper_a = data.pc;
			SEL_A_EX:  oper_a = data.ex_fwd;
			SEL_A_MEM: oper_a = data.mem_fwd;
			SEL_A_RS1: oper_a = data.rs1;
			default:   oper_a = '0;
		endcase
	end

	// Operand B, constant one is used for pc increments
	always_comb begin
		case (ctrl.sel_b)
			SEL_B_IMM: oper_b = data.imm;
			SEL_B_ONE: oper_b = `EX_XLEN'd1;
			SEL_B_EX:  oper_b = data.ex_fwd;
			SEL_B_MEM: oper_b = data.mem_fwd;
			SEL_B_RS2: oper_b = data.rs2;
			default:   oper_b = '0; // Codes 5..7 unused
		endcase
	end

	// Store data for sw
	always_comb begin
		case (ctrl.sel_st)
			SEL_ST_RS2: store_data = data.rs2;
			SEL_ST_EX:  store_data = data.ex_fwd;
			SEL_ST_MEM: store_data = data.mem_fwd;
			default:    store_data = '0;
		endcase
	end

	always_comb begin
		operands.oper_a     = oper_a;
		operands.oper_b     = oper_b;
		operands.store_data = store_data;
	end

endmodule

`default_nettype wire
